// ==== verilog.f ====
+incdir+rtl
rtl/shiftPkg.sv
rtl/shiftConfig.sv
rtl/shiftRegFile.sv
rtl/shiftDecode.sv
rtl/barrelShifter.sv
rtl/shiftUnit.sv
tests/shiftUnitTb.sv

// ==== tests/shiftUnitTb.sv ====
`include "shiftUnit_params.svh"

module shiftUnitTb import shiftPkg::*; ;

    localparam int W = `SHIFT_DATA_WIDTH;
    // the directed tests take about 500 cycles, so twice that marks a stuck run
    localparam int TIMEOUT_CYCLES = 1000;

    logic clk, rst, cfgWe, loadWe, issue, done, trap, illegal;
    configT cfgData, cfg, cfgModel;
    regAddrT loadAddr;
    wordT loadData;
    instrT instr;
    resultT result;
    wordT modelRegs [0:`SHIFT_REG_COUNT-1];
    int cycleCount = 0;
    int errorCount = 0;

    shiftUnit i_shiftUnit (
        .clk(clk), .rst(rst), .cfgWe(cfgWe), .cfgData(cfgData), .cfg(cfg),
        .loadWe(loadWe), .loadAddr(loadAddr), .loadData(loadData),
        .issue(issue), .instr(instr), .result(result), .done(done), .trap(trap),
        .illegal(illegal)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            abortRun();
        end
    end

    // ============================================================
    // reference model and helpers
    // ============================================================

    // bit-by-bit view of the 160-bit frames, frame position p of the left
    // frame holds a[p-n] and the result folds the upper half onto the lower
    function automatic wordT refShift(input logic [3:0] opc, input wordT a, input int n,
                                      output logic ov);
        wordT r;
        r = '0;
        ov = 1'b0;
        for (int i = 0; i < W; i++) begin
            case (opc)
                `OP_SHL: r[i] = (i >= n) ? a[i-n] : 1'b0;
                `OP_SHR: r[i] = (i + n < W) ? a[i+n] : 1'b0;
                `OP_ASR: r[i] = (i + n < W) ? a[i+n] : a[W-1];
                `OP_ROL: r[i] = ((i >= n) ? a[i-n] : 1'b0)
                              | ((i + W >= n && i + W - n < W) ? a[i+W-n] : 1'b0);
                `OP_ROR: r[i] = ((i + n < W) ? a[i+n] : 1'b0)
                              | ((i + n >= W && i + n - W < W) ? a[i+n-W] : 1'b0);
                default: r[i] = 1'b0;
            endcase
            // every frame position above bit 79 must match the sign
            // positions that no operand bit reaches count as zero
            if (opc == `OP_SHL)
                ov |= (((W + i >= n && W + i - n < W) ? a[W+i-n] : 1'b0) != a[W-1]);
        end
        return r;
    endfunction

    function automatic instrT makeInstr(input logic [3:0] opc, input regAddrT dest,
        input regAddrT srcA, input regAddrT srcB, input logic immSel, input amountT imm);
        return '{opcode: opc, dest: dest, srcA: srcA, srcB: srcB, immSel: immSel,
                 imm: imm, reserved: 3'b000};
    endfunction

    function automatic wordT randWord();
        return {16'($urandom), $urandom, $urandom};
    endfunction

    task automatic abortRun();
        errorCount++;
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkValue(input string testName, input string what,
                              input logic [W-1:0] expected, input logic [W-1:0] actual);
        if (actual !== expected) begin
            $display("error: %s %s expected %0h actual %0h", testName, what, expected, actual);
            abortRun();
        end
    endtask

    task automatic loadReg(input regAddrT addr, input wordT data);
        @(posedge clk);
        loadWe <= 1'b1;
        loadAddr <= addr;
        loadData <= data;
        @(posedge clk);
        loadWe <= 1'b0;
        modelRegs[addr] = data;
    endtask

    // a host write steers instructions issued from the next cycle on
    task automatic setConfig(input logic rot, input logic trapEn);
        @(posedge clk);
        cfgWe <= 1'b1;
        cfgData <= '{rotateEn: rot, ovTrapEn: trapEn};
        @(posedge clk);
        cfgWe <= 1'b0;
        cfgModel = '{rotateEn: rot, ovTrapEn: trapEn};
        @(negedge clk);
        checkValue("config", "cfg", cfgModel, cfg);
    endtask

    // issue one instruction and wait for done or illegal
    task automatic runOp(input string testName, input instrT ins);
        wordT expVal;
        logic expOv, expIllegal;
        int n, waited;
        n = ins.immSel ? ins.imm : modelRegs[ins.srcB][`SHIFT_AMT_WIDTH-1:0];
        expVal = refShift(ins.opcode, modelRegs[ins.srcA], n, expOv);
        expIllegal = !(ins.opcode inside {`OP_SHL, `OP_SHR, `OP_ASR}
                       || (cfgModel.rotateEn && ins.opcode inside {`OP_ROL, `OP_ROR}));
        @(posedge clk);
        issue <= 1'b1;
        instr <= ins;
        @(posedge clk);
        issue <= 1'b0;
        @(negedge clk);
        waited = 1;
        while (!done && !illegal && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        if (!done && !illegal) begin
            $display("%s: neither done nor illegal came within 8 cycles of issue", testName);
            abortRun();
        end
        checkValue(testName, "illegal", expIllegal, illegal);
        checkValue(testName, "latency", expIllegal ? 1 : 2, waited);
        if (expIllegal) begin
            @(negedge clk);
            checkValue(testName, "done after illegal", 0, done);
        end else begin
            checkValue(testName, "value", expVal, result.value);
            checkValue(testName, "overflow", expOv, result.overflow);
            checkValue(testName, "dest", ins.dest, result.dest);
            checkValue(testName, "trap", expOv && cfgModel.ovTrapEn, trap);
            modelRegs[ins.dest] = expVal;
        end
    endtask

    // legal instructions issued every gap cycles, done is due two cycles after each
    task automatic runStream(input string testName, input instrT prog[$], input int gap);
        wordT expVal[$];
        logic expOv[$];
        regAddrT expDest[$];
        logic slotBusy[$];
        instrT cur;
        wordT v;
        logic ov, busy;
        int n, total;
        total = (prog.size() - 1) * gap + 3;
        for (int c = 0; c < total; c++) begin
            @(posedge clk);
            busy = (c % gap == 0) && (c / gap < prog.size());
            slotBusy.push_back(busy);
            if (busy) begin
                cur = prog[c / gap];
                n = cur.immSel ? cur.imm : modelRegs[cur.srcB][`SHIFT_AMT_WIDTH-1:0];
                v = refShift(cur.opcode, modelRegs[cur.srcA], n, ov);
                expVal.push_back(v);
                expOv.push_back(ov);
                expDest.push_back(cur.dest);
                issue <= 1'b1;
                instr <= cur;
            end else begin
                issue <= 1'b0;
            end
            @(negedge clk);
            checkValue(testName, "illegal", 0, illegal);
            if (c >= 2) begin
                checkValue(testName, "done", slotBusy[c-2], done);
                if (slotBusy[c-2]) begin
                    checkValue(testName, "value", expVal[0], result.value);
                    checkValue(testName, "overflow", expOv[0], result.overflow);
                    checkValue(testName, "dest", expDest[0], result.dest);
                    checkValue(testName, "trap", expOv[0] && cfgModel.ovTrapEn, trap);
                    modelRegs[expDest[0]] = expVal.pop_front();
                    void'(expOv.pop_front());
                    void'(expDest.pop_front());
                end
            end
        end
    endtask

    // ============================================================
    // directed tests
    // ============================================================

    task automatic resetStateTest();
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            checkValue("reset", "done", 0, done);
            checkValue("reset", "trap", 0, trap);
            checkValue("reset", "illegal", 0, illegal);
            checkValue("reset", "cfg", 0, cfg);
        end
        for (int r = 0; r < `SHIFT_REG_COUNT; r++)
            runOp("reset_regs", makeInstr(`OP_SHL, r, r, r, 1'b1, 7'd0));
    endtask

    task automatic logicalShiftTest();
        int amts[5] = '{0, 1, 79, 80, 127};
        wordT w;
        foreach (amts[k]) begin
            for (int r = 0; r < 6; r++)
                loadReg(r, randWord());
            // register amounts come from the low 7 bits of register 6
            w = randWord();
            w[`SHIFT_AMT_WIDTH-1:0] = amts[k];
            loadReg(6, w);
            runOp("shl_imm", makeInstr(`OP_SHL, 3'($urandom_range(5)),
                  3'($urandom_range(5)), 3'd0, 1'b1, amts[k]));
            runOp("shr_imm", makeInstr(`OP_SHR, 3'($urandom_range(5)),
                  3'($urandom_range(5)), 3'd0, 1'b1, amts[k]));
            runOp("shl_reg", makeInstr(`OP_SHL, 3'($urandom_range(5)),
                  3'($urandom_range(5)), 3'd6, 1'b0, 7'($urandom)));
            runOp("shr_reg", makeInstr(`OP_SHR, 3'($urandom_range(5)),
                  3'($urandom_range(5)), 3'd6, 1'b0, 7'($urandom)));
        end
    endtask

    task automatic arithShiftTest();
        int amts[7] = '{0, 1, 40, 79, 80, 127, 5};
        foreach (amts[k]) begin
            loadReg(1, randWord() | {1'b1, {(W-1){1'b0}}});
            loadReg(2, randWord() & {1'b0, {(W-1){1'b1}}});
            runOp("asr_negative", makeInstr(`OP_ASR, 3'd3, 3'd1, 3'd0, 1'b1, amts[k]));
            runOp("asr_positive", makeInstr(`OP_ASR, 3'd4, 3'd2, 3'd0, 1'b1, amts[k]));
        end
    endtask

    task automatic rotateTest();
        int amts[7] = '{0, 1, 33, 79, 80, 81, 127};
        setConfig(1'b0, 1'b0);
        loadReg(2, randWord());
        loadReg(3, randWord());
        runOp("rotate_off", makeInstr(`OP_ROL, 3'd3, 3'd2, 3'd0, 1'b1, 7'd5));
        runOp("rotate_off", makeInstr(`OP_ROR, 3'd3, 3'd2, 3'd0, 1'b1, 7'd9));
        // reading register 3 back shows that the refused rotates left it alone
        runOp("rotate_off_dest", makeInstr(`OP_SHL, 3'd4, 3'd3, 3'd0, 1'b1, 7'd0));
        setConfig(1'b1, 1'b0);
        foreach (amts[k]) begin
            runOp("rol", makeInstr(`OP_ROL, 3'd3, 3'd2, 3'd0, 1'b1, amts[k]));
            runOp("ror", makeInstr(`OP_ROR, 3'd4, 3'd2, 3'd0, 1'b1, amts[k]));
        end
        runOp("bad_opcode", makeInstr(4'd0, 3'd5, 3'd2, 3'd0, 1'b1, 7'd1));
        runOp("bad_opcode", makeInstr(4'd6, 3'd5, 3'd2, 3'd0, 1'b1, 7'd1));
        runOp("bad_opcode", makeInstr(4'd15, 3'd5, 3'd2, 3'd0, 1'b1, 7'd1));
    endtask

    task automatic overflowTest();
        int amts[5] = '{0, 1, 2, 4, 80};
        for (int trapEn = 0; trapEn < 2; trapEn++) begin
            setConfig(1'b1, trapEn[0]);
            loadReg(0, 80'h1);
            loadReg(1, 80'h3 << 76);
            loadReg(2, randWord() | {1'b1, {(W-1){1'b0}}});
            loadReg(3, {W{1'b1}});
            for (int s = 0; s < 4; s++)
                foreach (amts[k])
                    runOp("shl_overflow", makeInstr(`OP_SHL, 3'd5, s, 3'd0, 1'b1, amts[k]));
        end
    endtask

    task automatic streamTest();
        instrT prog[$];
        setConfig(1'b1, 1'b1);
        for (int r = 0; r < 4; r++)
            loadReg(r, randWord());
        // sources in registers 0 to 3 and destinations in 4 to 7 keep the stream independent
        for (int i = 0; i < 10; i++)
            prog.push_back(makeInstr(4'($urandom_range(5, 1)), 3'($urandom_range(7, 4)),
                3'($urandom_range(3)), 3'($urandom_range(3)), 1'($urandom), 7'($urandom)));
        runStream("back_to_back", prog, 1);
        prog.delete();
        prog.push_back(makeInstr(`OP_SHL, 3'd4, 3'd0, 3'd0, 1'b1, 7'd3));
        prog.push_back(makeInstr(`OP_ROL, 3'd5, 3'd4, 3'd0, 1'b1, 7'd17));
        prog.push_back(makeInstr(`OP_ASR, 3'd6, 3'd5, 3'd4, 1'b0, 7'd0));
        prog.push_back(makeInstr(`OP_SHR, 3'd7, 3'd6, 3'd5, 1'b0, 7'd0));
        runStream("dependent", prog, 3);
    endtask

    initial begin
        void'($urandom(66884));
        rst = 1'b1;
        cfgWe = 1'b0;
        cfgData = '0;
        loadWe = 1'b0;
        loadAddr = '0;
        loadData = '0;
        issue = 1'b0;
        instr = '0;
        cfgModel = '0;
        foreach (modelRegs[r])
            modelRegs[r] = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        resetStateTest();
        logicalShiftTest();
        arithShiftTest();
        rotateTest();
        overflowTest();
        streamTest();
        if (errorCount == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            abortRun();
        end
    end

endmodule

// ==== rtl/shiftUnit.sv ====
module shiftUnit import shiftPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    cfgWe,
    input  configT  cfgData,
    output configT  cfg,
    input  logic    loadWe,
    input  regAddrT loadAddr,
    input  wordT    loadData,
    input  logic    issue,
    input  instrT   instr,
    output resultT  result,
    output logic    done,
    output logic    trap,
    output logic    illegal
);

    // ============================================================
    // internal nets
    // ============================================================

    regAddrT raAddr;
    regAddrT rbAddr;
    wordT    raData;
    wordT    rbData;
    issueT   issued;
    logic    issuedValid;

    // host enables, also visible on the top-level cfg port
    shiftConfig i_shiftConfig (
        .clk     (clk),
        .rst     (rst),
        .cfgWe   (cfgWe),
        .cfgData (cfgData),
        .cfg     (cfg)
    );

    // the writeback port is fed straight from the registered result,
    // so the write lands on the edge after done
    shiftRegFile i_shiftRegFile (
        .clk      (clk),
        .rst      (rst),
        .raAddr   (raAddr),
        .rbAddr   (rbAddr),
        .raData   (raData),
        .rbData   (rbData),
        .loadWe   (loadWe),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .wbWe     (done),
        .wbAddr   (result.dest),
        .wbData   (result.value)
    );

    // no forwarding path exists, a dependent instruction has to wait
    // three cycles to see the written value
    shiftDecode i_shiftDecode (
        .clk         (clk),
        .rst         (rst),
        .issue       (issue),
        .instr       (instr),
        .cfg         (cfg),
        .raAddr      (raAddr),
        .rbAddr      (rbAddr),
        .raData      (raData),
        .rbData      (rbData),
        .issued      (issued),
        .issuedValid (issuedValid),
        .illegal     (illegal)
    );

    barrelShifter i_barrelShifter (
        .clk         (clk),
        .rst         (rst),
        .issued      (issued),
        .issuedValid (issuedValid),
        .cfg         (cfg),
        .result      (result),
        .done        (done),
        .trap        (trap)
    );

endmodule

// ==== rtl/barrelShifter.sv ====
`include "shiftUnit_params.svh"

module barrelShifter import shiftPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  issueT  issued,
    input  logic   issuedValid,
    input  configT cfg,
    output resultT result,
    output logic   done,
    output logic   trap
);

    localparam int W = `SHIFT_DATA_WIDTH;

    // ============================================================
    // shift frames
    // ============================================================

    // left frame puts the operand at the bottom of a double-width word,
    // so whatever moves past bit W-1 lands in the upper half
    logic [2*W-1:0] shlFrame;
    // right frame puts the operand at the top, shifted-out bits fall
    // into the lower half
    logic [2*W-1:0] shrFrame;
    // mask of the vacated top positions for the arithmetic shift
    wordT           signFill;
    wordT           valueNext;
    logic           ovNext;
    wordT           a;

    assign a        = issued.operandA;
    assign shlFrame = {{W{1'b0}}, a} << issued.amount;
    assign shrFrame = {a, {W{1'b0}}} >> issued.amount;
    assign signFill = ~({W{1'b1}} >> issued.amount);

    always_comb begin
        case (issued.op)
            SHIFT_SHL: valueNext = shlFrame[W-1:0];
            SHIFT_SHR: valueNext = shrFrame[2*W-1:W];
            // negative operands get ones ORed into the vacated top bits
            SHIFT_ASR: valueNext = a[W-1] ? (shrFrame[2*W-1:W] | signFill)
                                          : shrFrame[2*W-1:W];
            // both halves folded together, this only behaves as a
            // true rotate while the amount stays within the word
            SHIFT_ROL: valueNext = shlFrame[W-1:0] | shlFrame[2*W-1:W];
            SHIFT_ROR: valueNext = shrFrame[W-1:0] | shrFrame[2*W-1:W];
            default:   valueNext = '0;
        endcase
    end

    // overflow means the bits pushed out the top differ from the input sign
    assign ovNext = (issued.op == SHIFT_SHL) && (shlFrame[2*W-1:W] != {W{a[W-1]}});

    // ============================================================
    // result register
    // ============================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            done <= 1'b0;
            trap <= 1'b0;
        end else begin
            done <= issuedValid;
            trap <= issuedValid && ovNext && cfg.ovTrapEn;
        end
    end

    always_ff @(posedge clk) begin
        if (issuedValid) begin
            result.value    <= valueNext;
            result.overflow <= ovNext;
            result.dest     <= issued.dest;
        end
    end

    // the trap is a qualifier of done and never stands alone
    assert property (@(posedge clk) disable iff (rst) trap |-> done)
        else $error("trap raised without done");

endmodule

// ==== rtl/shiftDecode.sv ====
`include "shiftUnit_params.svh"

module shiftDecode import shiftPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    issue,
    input  instrT   instr,
    input  configT  cfg,
    output regAddrT raAddr,
    output regAddrT rbAddr,
    input  wordT    raData,
    input  wordT    rbData,
    output issueT   issued,
    output logic    issuedValid,
    output logic    illegal
);

    // ============================================================
    // opcode cracking
    // ============================================================

    shiftOpT opNext;
    logic    legal;
    amountT  amountNext;

    // operand addresses follow the instruction bus directly
    // whether or not issue is high, the read is harmless
    assign raAddr = instr.srcA;
    assign rbAddr = instr.srcB;

    always_comb begin
        opNext = SHIFT_SHL;
        legal  = 1'b0;
        case (instr.opcode)
            `OP_SHL: begin
                opNext = SHIFT_SHL;
                legal  = 1'b1;
            end
            `OP_SHR: begin
                opNext = SHIFT_SHR;
                legal  = 1'b1;
            end
            `OP_ASR: begin
                opNext = SHIFT_ASR;
                legal  = 1'b1;
            end
            // rotates only exist while the host has enabled them
            `OP_ROL: begin
                opNext = SHIFT_ROL;
                legal  = cfg.rotateEn;
            end
            `OP_ROR: begin
                opNext = SHIFT_ROR;
                legal  = cfg.rotateEn;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    // register amounts use only the low bits of source b
    assign amountNext = instr.immSel ? instr.imm : rbData[`SHIFT_AMT_WIDTH-1:0];

    // ============================================================
    // issue register
    // ============================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            issuedValid <= 1'b0;
            illegal     <= 1'b0;
        end else begin
            issuedValid <= issue && legal;
            illegal     <= issue && !legal;
        end
    end

    // payload is only meaningful alongside issuedValid
    always_ff @(posedge clk) begin
        if (issue && legal) begin
            issued.op       <= opNext;
            issued.operandA <= raData;
            issued.amount   <= amountNext;
            issued.dest     <= instr.dest;
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(issuedValid && illegal))
        else $error("illegal and issuedValid high together");

endmodule

// ==== rtl/shiftRegFile.sv ====
`include "shiftUnit_params.svh"

module shiftRegFile import shiftPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  regAddrT raAddr,
    input  regAddrT rbAddr,
    output wordT    raData,
    output wordT    rbData,
    input  logic    loadWe,
    input  regAddrT loadAddr,
    input  wordT    loadData,
    input  logic    wbWe,
    input  regAddrT wbAddr,
    input  wordT    wbData
);

    // ============================================================
    // storage
    // ============================================================

    wordT regs [0:`SHIFT_REG_COUNT-1];

    // single write port shared by the host and the shifter
    // the writeback has priority when both ask in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `SHIFT_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wbWe) begin
            regs[wbAddr] <= wbData;
        end else if (loadWe) begin
            regs[loadAddr] <= loadData;
        end
    end

    // reads are combinational, so decode sees a written value
    // from the edge after the write cycle onward
    assign raData = regs[raAddr];
    assign rbData = regs[rbAddr];

    // an unknown write address would silently corrupt some register,
    // the writeback address comes from the result record two stages back
    property writeAddrKnown;
        @(posedge clk) disable iff (rst)
            (wbWe |-> !$isunknown(wbAddr)) and (loadWe |-> !$isunknown(loadAddr));
    endproperty

    assert property (writeAddrKnown)
        else $error("register file write with unknown address");

endmodule

// ==== rtl/shiftConfig.sv ====
module shiftConfig import shiftPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   cfgWe,
    input  configT cfgData,
    output configT cfg
);

    // ============================================================
    // configuration register
    // ============================================================

    // the enables only change on a host write strobe
    // decode and the trap logic read cfg directly, so a write in one
    // cycle steers an instruction issued in the very next cycle
    configT cfgQ;

    always_ff @(posedge clk) begin
        if (rst) begin
            // both features come up disabled
            cfgQ <= '0;
        end else if (cfgWe) begin
            cfgQ <= cfgData;
        end
    end

    assign cfg = cfgQ;

endmodule

// ==== rtl/shiftPkg.sv ====
`include "shiftUnit_params.svh"

package shiftPkg;

    // ============================================================
    // plain vector types
    // ============================================================

    // one data word, the unit of the register file and the shifter
    typedef logic [`SHIFT_DATA_WIDTH-1:0] wordT;

    // shift distance, either an immediate or the low bits of register b
    typedef logic [`SHIFT_AMT_WIDTH-1:0] amountT;

    // register file index
    typedef logic [$clog2(`SHIFT_REG_COUNT)-1:0] regAddrT;

    // ============================================================
    // instruction and pipeline records
    // ============================================================

    // instruction layout from the top bit down, 24 bits in all
    typedef struct packed {
        logic [3:0] opcode;
        regAddrT    dest;
        regAddrT    srcA;
        regAddrT    srcB;
        logic       immSel;
        amountT     imm;
        logic [2:0] reserved;
    } instrT;

    // operations the shifter knows once decode has accepted the opcode
    typedef enum logic [2:0] {
        SHIFT_SHL,
        SHIFT_SHR,
        SHIFT_ASR,
        SHIFT_ROL,
        SHIFT_ROR
    } shiftOpT;

    // what decode hands to the execute stage
    typedef struct packed {
        shiftOpT op;
        wordT    operandA;
        amountT  amount;
        regAddrT dest;
    } issueT;

    // what execute reports and writes back
    typedef struct packed {
        wordT    value;
        logic    overflow;
        regAddrT dest;
    } resultT;

    // host-controlled enables
    typedef struct packed {
        logic rotateEn;
        logic ovTrapEn;
    } configT;

endpackage

// ==== rtl/shiftUnit_params.svh ====
`ifndef SHIFTUNIT_PARAMS_SVH
`define SHIFTUNIT_PARAMS_SVH

// ============================================================
// datapath sizing
// ============================================================

// operand and result width of the shift slice
`define SHIFT_DATA_WIDTH 80

// a 7-bit amount reaches 127, past the word width on purpose
`define SHIFT_AMT_WIDTH 7

// eight architectural registers, addressed with three bits
`define SHIFT_REG_COUNT 8

// instruction word as issued to the slice
`define SHIFT_INSTR_WIDTH 24

// ============================================================
// opcode encodings
// ============================================================

// code 0 and codes 6 to 15 are illegal for this slice
`define OP_SHL 4'd1
`define OP_SHR 4'd2
`define OP_ASR 4'd3
`define OP_ROL 4'd4
`define OP_ROR 4'd5

`endif
